// File: Makefile
# Verilator build and run for the writeback stage testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_wb_top
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Run and fail unless the pass message appears on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_wb_top.sv
/*
 Directed testbench for wb_top with a model of the PRF and of each lane's
 two-entry result buffer. Inputs change 1 ns after the rising edge and
 outputs are sampled at the falling edge. Random data comes from an LFSR.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_wb_top;
   import wb_pkg::*;

   localparam int          CLK_PERIOD     = 40;
   localparam int          DRIVE_DELAY    = 1;
   localparam int          RESET_CYCLES   = 3;
   localparam int          TIMEOUT_CYCLES = 2000;
   localparam int          FIRE_WAIT      = 20;
   localparam int          RANDOM_CYCLES  = 80;
   localparam logic [31:0] LFSR_SEED      = 32'hbe61;

   // DUT ports
   logic                         clk;
   logic                         rst_n;
   logic [WB_LANES-1:0]          ex_valid;
   logic [WB_LANES*PRF_AW-1:0]   ex_waddr;
   logic [WB_LANES*WB_DW-1:0]    ex_wdata;
   logic [WB_LANES-1:0]          ex_ready;
   logic                         lsu_we;
   logic [PRF_AW-1:0]            lsu_waddr;
   logic [WB_DW-1:0]             lsu_wdata;
   logic [WB_LANES-1:0]          rob_ready;
   logic [WB_LANES-1:0]          wb_fire;
   logic [PRF_RPORTS*PRF_AW-1:0] rd_addr;
   logic [PRF_RPORTS*WB_DW-1:0]  rd_data;

   // Model of the register file and the lane FIFOs
   logic [WB_DW-1:0]  model [1<<PRF_AW];
   logic [PRF_AW-1:0] q_addr [WB_LANES][WB_BUF_DEPTH];
   logic [WB_DW-1:0]  q_data [WB_LANES][WB_BUF_DEPTH];
   int                q_cnt [WB_LANES];

   // Outputs seen at the last falling edge
   logic [WB_LANES-1:0]         seen_fire;
   logic [WB_LANES-1:0]         seen_ready;
   logic [PRF_RPORTS*WB_DW-1:0] seen_rd;

   logic [31:0] lfsr_q;
   int          error_cnt;
   int          test_errs;
   int          tests_run;
   int          tests_failed;
   int          cycle_cnt;

   wb_top uut
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .ex_valid  (ex_valid),
      .ex_waddr  (ex_waddr),
      .ex_wdata  (ex_wdata),
      .ex_ready  (ex_ready),
      .lsu_we    (lsu_we),
      .lsu_waddr (lsu_waddr),
      .lsu_wdata (lsu_wdata),
      .rob_ready (rob_ready),
      .wb_fire   (wb_fire),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // Cycle limit for the whole run
   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Run stopped after %0d cycles without finishing the tests", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // Galois step with taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int b = 0; b < n; b++)
      begin
         lfsr_q = lfsr_step(lfsr_q);
         v[b] = lfsr_q[0];
      end
      return v;
   endfunction

   task automatic report_error(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      error_cnt++;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (error_cnt == test_errs)
      begin
         $display("Test %s done, no errors", name);
      end
      else
      begin
         tests_failed++;
         $display("Test %s done with %0d errors", name, error_cnt - test_errs);
      end
      test_errs = error_cnt;
   endtask

   task automatic set_read(input int port, input logic [PRF_AW-1:0] addr);
      rd_addr[port*PRF_AW +: PRF_AW] = addr;
   endtask

   // Check outputs at the falling edge, advance the model, then step past the edge
   task automatic clock_and_check();
      logic [WB_LANES-1:0] exp_fire;
      logic [WB_LANES-1:0] exp_ready;
      logic [PRF_AW-1:0]   a;
      @(negedge clk);
      seen_fire = wb_fire;
      seen_ready = ex_ready;
      seen_rd = rd_data;
      // Reads show every write up to the last edge
      for (int p = 0; p < PRF_RPORTS; p++)
      begin
         a = rd_addr[p*PRF_AW +: PRF_AW];
         assert (rd_data[p*WB_DW +: WB_DW] === model[a])
         else report_error($sformatf("read port %0d addr %0d gave %h, expected %h",
                                     p, a, rd_data[p*WB_DW +: WB_DW], model[a]));
      end
      // Room below depth, pop needs a head and ROB ready, LSU holds lane 0
      for (int l = 0; l < WB_LANES; l++)
      begin
         exp_ready[l] = (q_cnt[l] < WB_BUF_DEPTH);
         exp_fire[l] = (q_cnt[l] != 0) && rob_ready[l] && !(l == 0 && lsu_we);
      end
      assert (ex_ready === exp_ready)
      else report_error($sformatf("ex_ready %b, expected %b", ex_ready, exp_ready));
      assert (wb_fire === exp_fire)
      else report_error($sformatf("wb_fire %b, expected %b", wb_fire, exp_fire));
      // Lane order so lane 1 overrides lane 0 and the LSU
      if (lsu_we)
      begin
         model[lsu_waddr] = lsu_wdata;
      end
      for (int l = 0; l < WB_LANES; l++)
      begin
         if (exp_fire[l])
         begin
            model[q_addr[l][0]] = q_data[l][0];
            for (int e = 0; e < WB_BUF_DEPTH - 1; e++)
            begin
               q_addr[l][e] = q_addr[l][e+1];
               q_data[l][e] = q_data[l][e+1];
            end
            q_cnt[l]--;
         end
         if (ex_valid[l] && exp_ready[l])
         begin
            q_addr[l][q_cnt[l]] = ex_waddr[l*PRF_AW +: PRF_AW];
            q_data[l][q_cnt[l]] = ex_wdata[l*WB_DW +: WB_DW];
            q_cnt[l]++;
         end
      end
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic send_result(input int lane, input logic [PRF_AW-1:0] addr,
                              input logic [WB_DW-1:0] data);
      ex_valid[lane] = 1'b1;
      ex_waddr[lane*PRF_AW +: PRF_AW] = addr;
      ex_wdata[lane*WB_DW +: WB_DW] = data;
      clock_and_check();
      ex_valid[lane] = 1'b0;
   endtask

   task automatic wait_fire(input int lane);
      int n;
      n = 0;
      seen_fire = '0;
      while (!seen_fire[lane] && n < FIRE_WAIT)
      begin
         clock_and_check();
         n++;
      end
      assert (seen_fire[lane])
      else
      begin
         $display("Lane %0d raised no wb_fire within %0d cycles", lane, FIRE_WAIT);
         error_cnt++;
      end
   endtask

   // Sweep all registers through the four read ports
   task automatic read_all_registers();
      for (int b = 0; b < (1 << PRF_AW); b += PRF_RPORTS)
      begin
         for (int p = 0; p < PRF_RPORTS; p++)
         begin
            set_read(p, PRF_AW'(b + p));
         end
         clock_and_check();
      end
   endtask

   task automatic test_reset_state();
      clock_and_check();
      assert (seen_ready === '1) else report_error("ex_ready not all ones after reset");
      assert (seen_fire === '0) else report_error("wb_fire high after reset");
      read_all_registers();
      end_test("reset_state");
   endtask

   task automatic test_single_lane();
      logic [PRF_AW-1:0] a;
      logic [WB_DW-1:0]  d;
      rob_ready = '1;
      for (int l = 0; l < WB_LANES; l++)
      begin
         a = PRF_AW'(8 + l);
         d = rand_bits(WB_DW);
         set_read(0, a);
         send_result(l, a, d);
         wait_fire(l);
         clock_and_check();
         assert (seen_fire === '0) else report_error("wb_fire pulsed more than once");
         assert (seen_rd[0 +: WB_DW] === d)
         else report_error($sformatf("lane %0d read %h, wrote %h", l, seen_rd[0 +: WB_DW], d));
      end
      end_test("single_lane");
   endtask

   task automatic test_back_pressure();
      logic [PRF_AW-1:0] a;
      logic [WB_DW-1:0]  d_old;
      logic [WB_DW-1:0]  d_new;
      for (int l = 0; l < WB_LANES; l++)
      begin
         a = PRF_AW'(20 + l);
         d_old = rand_bits(WB_DW);
         d_new = rand_bits(WB_DW);
         set_read(0, a);
         rob_ready[l] = 1'b0;
         send_result(l, a, d_old);
         send_result(l, a, d_new);
         clock_and_check();
         assert (!seen_ready[l]) else report_error("ex_ready high with a full lane");
         assert (!seen_fire[l]) else report_error("wb_fire while the ROB is not ready");
         rob_ready[l] = 1'b1;
         // Older head leaves first
         clock_and_check();
         assert (seen_fire[l]) else report_error("no wb_fire after rob_ready rose");
         clock_and_check();
         assert (seen_fire[l] && seen_ready[l]) else report_error("second entry not popped");
         assert (seen_rd[0 +: WB_DW] === d_old) else report_error("older value not written first");
         clock_and_check();
         assert (seen_rd[0 +: WB_DW] === d_new) else report_error("newer value not final");
      end
      end_test("back_pressure");
   endtask

   task automatic test_lsu_priority();
      logic [PRF_AW-1:0] a;
      logic [WB_DW-1:0]  d_ex;
      logic [WB_DW-1:0]  d_lsu;
      a = PRF_AW'(40);
      d_ex = rand_bits(WB_DW);
      d_lsu = rand_bits(WB_DW);
      rob_ready = '1;
      set_read(0, a);
      send_result(0, a, d_ex);
      // LSU and lane-0 head together
      lsu_we = 1'b1;
      lsu_waddr = a;
      lsu_wdata = d_lsu;
      clock_and_check();
      assert (!seen_fire[0]) else report_error("lane 0 fired during an LSU write");
      lsu_we = 1'b0;
      clock_and_check();
      assert (seen_rd[0 +: WB_DW] === d_lsu) else report_error("LSU value did not land first");
      assert (seen_fire[0]) else report_error("lane 0 head not written after the LSU");
      clock_and_check();
      assert (seen_rd[0 +: WB_DW] === d_ex) else report_error("execution value not final");
      end_test("lsu_priority");
   endtask

   task automatic test_lane_conflict();
      logic [PRF_AW-1:0] a;
      logic [WB_DW-1:0]  d0;
      logic [WB_DW-1:0]  d1;
      a = PRF_AW'(50);
      d0 = rand_bits(WB_DW);
      d1 = rand_bits(WB_DW);
      rob_ready = '1;
      set_read(0, a);
      ex_valid = '1;
      ex_waddr = {a, a};
      ex_wdata = {d1, d0};
      clock_and_check();
      ex_valid = '0;
      clock_and_check();
      assert (seen_fire === '1) else report_error("both lanes should fire together");
      clock_and_check();
      assert (seen_rd[0 +: WB_DW] === d1) else report_error("lane 1 lost the address conflict");
      // Random traffic on every lane and the LSU
      repeat (RANDOM_CYCLES)
      begin
         ex_valid = WB_LANES'(rand_bits(WB_LANES));
         ex_waddr = (WB_LANES*PRF_AW)'(rand_bits(WB_LANES*PRF_AW));
         for (int l = 0; l < WB_LANES; l++)
         begin
            ex_wdata[l*WB_DW +: WB_DW] = rand_bits(WB_DW);
         end
         rob_ready = WB_LANES'(rand_bits(WB_LANES));
         lsu_we = (rand_bits(2) == 64'd3);
         lsu_waddr = PRF_AW'(rand_bits(PRF_AW));
         lsu_wdata = rand_bits(WB_DW);
         rd_addr = (PRF_RPORTS*PRF_AW)'(rand_bits(PRF_RPORTS*PRF_AW));
         clock_and_check();
      end
      // Drain the lanes
      ex_valid = '0;
      lsu_we = 1'b0;
      rob_ready = '1;
      repeat (WB_BUF_DEPTH + 1) clock_and_check();
      read_all_registers();
      end_test("lane_conflict");
   endtask

   initial
   begin
      rst_n = 1'b0;
      ex_valid = '0;
      ex_waddr = '0;
      ex_wdata = '0;
      lsu_we = 1'b0;
      lsu_waddr = '0;
      lsu_wdata = '0;
      rob_ready = '0;
      rd_addr = '0;
      lfsr_q = LFSR_SEED;
      error_cnt = 0;
      test_errs = 0;
      tests_run = 0;
      tests_failed = 0;
      for (int r = 0; r < (1 << PRF_AW); r++)
      begin
         model[r] = '0;
      end
      for (int l = 0; l < WB_LANES; l++)
      begin
         q_cnt[l] = 0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;
      test_reset_state();
      test_single_lane();
      test_back_pressure();
      test_lsu_priority();
      test_lane_conflict();
      $display("Summary: %0d tests, %0d with errors, %0d errors in total",
               tests_run, tests_failed, error_cnt);
      if (error_cnt == 0 && tests_failed == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
verilog/wb_pkg.sv
verilog/wb_bus_if.sv
verilog/wb_result_buf.sv
verilog/wb_mux.sv
verilog/prf.sv
verilog/wb_top.sv
tests/tb_wb_top.sv

// File: verilog/prf.sv
/*
 Physical register file with WB_LANES write ports and PRF_RPORTS reads.
 Reads are combinational with no bypass, so a write shows after its edge.
 On a same-address conflict the highest-numbered write port wins.
 */
`timescale 1ns/100ps
`default_nettype none

module prf
(
   input  logic                                         clk,
   input  logic                                         rst_n,
   // Write ports
   input  logic [wb_pkg::WB_LANES-1:0]                  we,
   input  logic [wb_pkg::WB_LANES*wb_pkg::PRF_AW-1:0]   waddr,
   input  logic [wb_pkg::WB_LANES*wb_pkg::WB_DW-1:0]    wdata,
   // Read ports
   input  logic [wb_pkg::PRF_RPORTS*wb_pkg::PRF_AW-1:0] raddr,
   output logic [wb_pkg::PRF_RPORTS*wb_pkg::WB_DW-1:0]  rdata
);
   import wb_pkg::*;

   genvar p;

   // Storage array
   logic [WB_DW-1:0] regs_q [1<<PRF_AW];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         // All registers start at zero
         for (int r = 0; r < (1 << PRF_AW); r++)
         begin
            regs_q[r] <= '0;
         end
      end
      else
      begin
         // Lane order so the last lane overrides
         for (int l = 0; l < WB_LANES; l++)
         begin
            if (we[l])
            begin
               regs_q[waddr[l*PRF_AW +: PRF_AW]] <= wdata[l*WB_DW +: WB_DW];
            end
         end
      end
   end

   // Combinational reads
   generate
      for (p = 0; p < PRF_RPORTS; p = p + 1)
      begin : gen_rport
         assign rdata[p*WB_DW +: WB_DW] = regs_q[raddr[p*PRF_AW +: PRF_AW]];
      end
   endgenerate

endmodule

`default_nettype wire

// File: verilog/wb_bus_if.sv
/*
 Link between the per-lane result buffers and the writeback mux.
 Lane i uses bit i of the valid and ready masks and slice i of address
 and data. A head leaves its buffer on an edge with valid and ready high.
 */
`timescale 1ns/100ps
`default_nettype none

interface wb_bus_if;
   import wb_pkg::*;

   // Oldest buffered result of each lane
   logic [WB_LANES-1:0]        head_valid;
   logic [WB_LANES*PRF_AW-1:0] head_waddr;
   logic [WB_LANES*WB_DW-1:0]  head_wdata;

   // Pop permission back from the mux
   // Already folds in ROB ready and LSU priority
   logic [WB_LANES-1:0]        pop_ready;

   // Result buffer side
   modport rbuf
   (
      output head_valid,
      output head_waddr,
      output head_wdata,
      input  pop_ready
   );

   // Mux side
   modport mux
   (
      input  head_valid,
      input  head_waddr,
      input  head_wdata,
      output pop_ready
   );

endinterface

`default_nettype wire

// File: verilog/wb_mux.sv
/*
 Writeback steering, purely combinational.
 The LSU owns PRF write port 0 whenever lsu_we is high and has no ready;
 the lane-0 execution head then waits. LSU writes never raise wb_fire.
 */
`timescale 1ns/100ps
`default_nettype none

module wb_mux
(
   // From LSU
   input  logic                                       lsu_we,
   input  logic [wb_pkg::PRF_AW-1:0]                  lsu_waddr,
   input  logic [wb_pkg::WB_DW-1:0]                   lsu_wdata,
   // From ROB
   input  logic [wb_pkg::WB_LANES-1:0]                rob_ready,
   // From the result buffers
   wb_bus_if.mux                                      bus,
   // To PRF
   output logic [wb_pkg::WB_LANES-1:0]                prf_we,
   output logic [wb_pkg::WB_LANES*wb_pkg::PRF_AW-1:0] prf_waddr,
   output logic [wb_pkg::WB_LANES*wb_pkg::WB_DW-1:0]  prf_wdata,
   // To ROB
   output logic [wb_pkg::WB_LANES-1:0]                wb_fire
);
   import wb_pkg::*;

   genvar i;

   // LSU blocks only lane 0
   assign bus.pop_ready = rob_ready & ~{{(WB_LANES-1){1'b0}}, lsu_we};

   // Execution head written on every lane that pops
   assign wb_fire = bus.head_valid & bus.pop_ready;

   // Lane 0 arbiter with LSU priority
   assign prf_we[0] = lsu_we | wb_fire[0];
   assign prf_waddr[0 +: PRF_AW] = lsu_we ? lsu_waddr : bus.head_waddr[0 +: PRF_AW];
   assign prf_wdata[0 +: WB_DW] = lsu_we ? lsu_wdata : bus.head_wdata[0 +: WB_DW];

   // Remaining lanes go straight through
   generate
      for (i = 1; i < WB_LANES; i = i + 1)
      begin : gen_lane
         assign prf_we[i] = wb_fire[i];
         assign prf_waddr[i*PRF_AW +: PRF_AW] = bus.head_waddr[i*PRF_AW +: PRF_AW];
         assign prf_wdata[i*WB_DW +: WB_DW] = bus.head_wdata[i*WB_DW +: WB_DW];
      end
   endgenerate

endmodule

`default_nettype wire

// File: verilog/wb_pkg.sv
/*
 Sizes shared by the writeback stage, buffer, mux and register file.
 WB_LANES must stay a power of two and WB_BUF_DEPTH must be a power of two,
 because buffer pointers are WB_BUF_CW-1 bits wide and wrap naturally.
 */
`default_nettype none

package wb_pkg;

   // Result data word
   localparam int WB_DW        = 64;

   // Log2 of the writeback lane count
   localparam int WB_P_WIDTH   = 1;

   // Lanes derived from the log2 width
   localparam int WB_LANES     = (1 << WB_P_WIDTH);

   // Physical register address
   // 64 registers in the PRF
   localparam int PRF_AW       = 6;

   // Combinational read ports on the PRF
   localparam int PRF_RPORTS   = 4;

   // Entries held per lane before ex_ready drops
   localparam int WB_BUF_DEPTH = 2;

   // Occupancy count width
   // Must reach WB_BUF_DEPTH itself
   localparam int WB_BUF_CW    = 2;

endpackage

`default_nettype wire

// File: verilog/wb_result_buf.sv
/*
 Per-lane result FIFOs of WB_BUF_DEPTH entries between EX and writeback.
 ex_ready comes from registered occupancy only, so a full lane accepts
 again only on the edge after its head pops. Payload storage has no reset.
 */
`timescale 1ns/100ps
`default_nettype none

module wb_result_buf
(
   input  logic                                       clk,
   input  logic                                       rst_n,
   // From EX
   input  logic [wb_pkg::WB_LANES-1:0]                ex_valid,
   input  logic [wb_pkg::WB_LANES*wb_pkg::PRF_AW-1:0] ex_waddr,
   input  logic [wb_pkg::WB_LANES*wb_pkg::WB_DW-1:0]  ex_wdata,
   output logic [wb_pkg::WB_LANES-1:0]                ex_ready,
   // To the mux
   wb_bus_if.rbuf                                     bus
);
   import wb_pkg::*;

   genvar i;

   generate
      for (i = 0; i < WB_LANES; i = i + 1)
      begin : gen_lane
         // Entry payloads
         logic [PRF_AW-1:0]    addr_q [WB_BUF_DEPTH];
         logic [WB_DW-1:0]     data_q [WB_BUF_DEPTH];
         // Pointers one bit narrower than the count
         logic [WB_BUF_CW-2:0] wr_ptr;
         logic [WB_BUF_CW-2:0] rd_ptr;
         logic [WB_BUF_CW-1:0] cnt;
         logic                 push;
         logic                 pop;

         // Room left in this lane
         assign ex_ready[i] = (cnt < WB_BUF_CW'(WB_BUF_DEPTH));

         // EX handshake
         assign push = ex_valid[i] & ex_ready[i];

         // Head taken by the mux this cycle
         assign pop = bus.head_valid[i] & bus.pop_ready[i];

         // Oldest entry goes out to the mux
         assign bus.head_valid[i] = (cnt != '0);
         assign bus.head_waddr[i*PRF_AW +: PRF_AW] = addr_q[rd_ptr];
         assign bus.head_wdata[i*WB_DW +: WB_DW] = data_q[rd_ptr];

         // Payload write at the tail
         always_ff @(posedge clk)
         begin
            if (push)
            begin
               addr_q[wr_ptr] <= ex_waddr[i*PRF_AW +: PRF_AW];
               data_q[wr_ptr] <= ex_wdata[i*WB_DW +: WB_DW];
            end
         end

         // Pointers and occupancy
         always_ff @(posedge clk or negedge rst_n)
         begin
            if (!rst_n)
            begin
               wr_ptr <= '0;
               rd_ptr <= '0;
               cnt <= '0;
            end
            else
            begin
               if (push)
               begin
                  wr_ptr <= wr_ptr + 1'b1;
               end
               if (pop)
               begin
                  rd_ptr <= rd_ptr + 1'b1;
               end
               // Push and pop together leave the count alone
               case ({push, pop})
                  2'b10:
                  begin
                     cnt <= cnt + 1'b1;
                  end
                  2'b01:
                  begin
                     cnt <= cnt - 1'b1;
                  end
                  default:
                  begin
                     cnt <= cnt;
                  end
               endcase
            end
         end
      end
   endgenerate

endmodule

`default_nettype wire

// File: verilog/wb_top.sv
/*
 Writeback stage top with plain packed ports.
 EX results land in the PRF no earlier than the edge after acceptance;
 LSU writes land at the edge where lsu_we is high. No rename, ROB or LSU.
 */
`timescale 1ns/100ps
`default_nettype none

module wb_top
(
   input  logic                                         clk,
   input  logic                                         rst_n,
   // From EX lanes
   input  logic [wb_pkg::WB_LANES-1:0]                  ex_valid,
   input  logic [wb_pkg::WB_LANES*wb_pkg::PRF_AW-1:0]   ex_waddr,
   input  logic [wb_pkg::WB_LANES*wb_pkg::WB_DW-1:0]    ex_wdata,
   output logic [wb_pkg::WB_LANES-1:0]                  ex_ready,
   // From LSU
   input  logic                                         lsu_we,
   input  logic [wb_pkg::PRF_AW-1:0]                    lsu_waddr,
   input  logic [wb_pkg::WB_DW-1:0]                     lsu_wdata,
   // ROB handshake
   input  logic [wb_pkg::WB_LANES-1:0]                  rob_ready,
   output logic [wb_pkg::WB_LANES-1:0]                  wb_fire,
   // PRF reads
   input  logic [wb_pkg::PRF_RPORTS*wb_pkg::PRF_AW-1:0] rd_addr,
   output logic [wb_pkg::PRF_RPORTS*wb_pkg::WB_DW-1:0]  rd_data
);
   import wb_pkg::*;

   // Mux to PRF write ports
   logic [WB_LANES-1:0]        prf_we;
   logic [WB_LANES*PRF_AW-1:0] prf_waddr;
   logic [WB_LANES*WB_DW-1:0]  prf_wdata;

   // Buffer heads and pop mask
   wb_bus_if bus_i ();

   // Per-lane result FIFOs
   wb_result_buf u_buf
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .ex_valid (ex_valid),
      .ex_waddr (ex_waddr),
      .ex_wdata (ex_wdata),
      .ex_ready (ex_ready),
      .bus      (bus_i)
   );

   // LSU arbitration and write steering
   wb_mux u_mux
   (
      .lsu_we    (lsu_we),
      .lsu_waddr (lsu_waddr),
      .lsu_wdata (lsu_wdata),
      .rob_ready (rob_ready),
      .bus       (bus_i),
      .prf_we    (prf_we),
      .prf_waddr (prf_waddr),
      .prf_wdata (prf_wdata),
      .wb_fire   (wb_fire)
   );

   // Register file
   prf u_prf
   (
      .clk   (clk),
      .rst_n (rst_n),
      .we    (prf_we),
      .waddr (prf_waddr),
      .wdata (prf_wdata),
      .raddr (rd_addr),
      .rdata (rd_data)
   );

endmodule

`default_nettype wire
